//--- axis_pkg.sv
// ********************
// Stream-side definitions for the four-port transmit path
// Referenced by scoped name from the distributor, queues and top level
// ********************
`default_nettype none

package axis_pkg;

   // Number of transmit queues behind the distributor
   localparam int NUM_PORTS = 4;

   // ********************
   // Stream widths
   // ********************
   typedef logic [63:0] data_t;
   typedef logic [7:0]  strb_t;

   // Queue index carried on tdest
   typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

   // One accepted beat as handed to a queue
   // last already includes the short-strobe end rule
   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } axis_beat_t;

endpackage

`default_nettype wire

//--- mac_pkg.sv
// ********************
// MAC-side definitions for the stored FIFO word, the MAC word,
// the queue FSM states and FIFO sizing
// Referenced by scoped name from the queues and arbiter
// ********************
`default_nettype none

package mac_pkg;

   // Valid bytes minus one
   // Code 8 flags a strobe that could not be encoded
   typedef logic [3:0] byte_code_t;

   // Byte-valid mask as seen by the MAC
   typedef logic [7:0] byte_valid_t;

   // ********************
   // Queue storage sizing
   // ********************
   localparam int FIFO_DEPTH   = 64;
   localparam int AFULL_MARGIN = 16;

   typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_addr_t;
   typedef logic [6:0]                    frame_cnt_t;

   // Word held in a queue FIFO
   typedef struct packed {
      logic              eop;
      byte_code_t        code;
      axis_pkg::data_t   data;
   } fifo_word_t;

   // Word presented to the MAC
   typedef struct packed {
      axis_pkg::data_t data;
      byte_valid_t     valid;
   } mac_word_t;

   typedef enum logic [1:0] {
      IDLE,
      WAIT_FOR_ACK,
      SEND_PKT,
      IFG
   } queue_state_e;

endpackage

`default_nettype wire

//--- frame_distributor.sv
// ********************
// Steers stream frames into one of the transmit queues
// Port is taken from tdest on the first beat and held to the end beat
// ********************
`default_nettype none

module frame_distributor (
   input  wire  logic                          clk156,
   input  wire  logic                          reset,
   input  wire  axis_pkg::data_t               tdata,
   input  wire  axis_pkg::strb_t               tstrb,
   input  wire  logic                          tvalid,
   input  wire  logic                          tlast,
   input  wire  axis_pkg::port_t               tdest,
   input  wire  logic [axis_pkg::NUM_PORTS-1:0] almost_full,
   output logic                                tready,
   output axis_pkg::axis_beat_t                beat,
   output logic [axis_pkg::NUM_PORTS-1:0]      wr_en
);

   axis_pkg::port_t cur_port;
   axis_pkg::port_t sel_port;
   logic            in_frame;
   logic            accept;
   logic            end_beat;

   // Mid-frame beats follow the latched port and first beats follow tdest
   assign sel_port = in_frame ? cur_port : tdest;
   assign tready   = ~almost_full[sel_port];
   assign accept   = tvalid & tready;

   // A short strobe ends the frame even without tlast
   assign end_beat = tlast | (tstrb != '1);

   assign beat.data = tdata;
   assign beat.strb = tstrb;
   assign beat.last = end_beat;

   always_comb begin
      wr_en = '0;
      wr_en[sel_port] = accept;
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         in_frame <= 1'b0;
      end else if (accept) begin
         in_frame <= ~end_beat;
      end
   end

   always_ff @(posedge clk156) begin
      if (accept && !in_frame) begin
         cur_port <= tdest;
      end
   end

   // Queue encoder only understands strobes of the form 0..01..1
   a_strb_contiguous : assert property (@(posedge clk156) disable iff (reset)
      accept |-> (tstrb != '0) && ((tstrb & axis_pkg::strb_t'(tstrb + 1'b1)) == '0))
      else $error("non-contiguous or empty strobe accepted");

endmodule

`default_nettype wire

//--- tx_frame_fifo.sv
// ********************
// Synchronous word FIFO with first-word fall-through output
// almost_full leaves room for the words still in flight upstream
// ********************
`default_nettype none

module tx_frame_fifo (
   input  wire logic                 clk156,
   input  wire logic                 reset,
   input  wire logic                 wr_en,
   input  wire mac_pkg::fifo_word_t  wdata,
   input  wire logic                 rd_en,
   output mac_pkg::fifo_word_t       rdata,
   output logic                      empty,
   output logic                      almost_full
);

   mac_pkg::fifo_word_t mem [mac_pkg::FIFO_DEPTH];

   mac_pkg::fifo_addr_t wr_ptr;
   mac_pkg::fifo_addr_t rd_ptr;
   logic [$clog2(mac_pkg::FIFO_DEPTH):0] fill;
   logic full;

   // Head word is always visible
   assign rdata = mem[rd_ptr];

   assign empty       = (fill == '0);
   assign full        = (int'(fill) == mac_pkg::FIFO_DEPTH);
   assign almost_full = (mac_pkg::FIFO_DEPTH - int'(fill)) < mac_pkg::AFULL_MARGIN;

   always_ff @(posedge clk156) begin
      if (wr_en) begin
         mem[wr_ptr] <= wdata;
      end
   end

   // ********************
   // Pointers and fill level
   // ********************
   always_ff @(posedge clk156) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   a_no_overflow : assert property (@(posedge clk156) disable iff (reset)
      wr_en |-> !full)
      else $error("write into full FIFO");

   a_no_underflow : assert property (@(posedge clk156) disable iff (reset)
      rd_en |-> !empty)
      else $error("read from empty FIFO");

endmodule

`default_nettype wire

//--- tx_queue.sv
// ********************
// Per-port stream to MAC converter
// Stores whole frames, requests the MAC with tx_start and plays a frame
// out one word per cycle once tx_ack arrives
// ********************
`default_nettype none

module tx_queue (
   input  wire logic                  clk156,
   input  wire logic                  reset,
   input  wire logic                  wr_en,
   input  wire axis_pkg::axis_beat_t  beat,
   input  wire logic                  tx_ack,
   output logic                       almost_full,
   output logic                       tx_start,
   output logic                       tx_active,
   output mac_pkg::mac_word_t         mac_out
);

   mac_pkg::queue_state_e state;
   mac_pkg::queue_state_e state_next;

   mac_pkg::byte_code_t   strb_code;
   mac_pkg::byte_valid_t  valid_mask;
   mac_pkg::fifo_word_t   wr_word;
   mac_pkg::fifo_word_t   rd_word;
   mac_pkg::frame_cnt_t   frame_cnt;

   logic fifo_empty;
   logic rd_en;
   logic frame_done;
   logic frame_take;

   // ********************
   // Write side
   // ********************
   always_comb begin
      case (beat.strb)
         8'h01:   strb_code = 4'h0;
         8'h03:   strb_code = 4'h1;
         8'h07:   strb_code = 4'h2;
         8'h0f:   strb_code = 4'h3;
         8'h1f:   strb_code = 4'h4;
         8'h3f:   strb_code = 4'h5;
         8'h7f:   strb_code = 4'h6;
         8'hff:   strb_code = 4'h7;
         default: strb_code = 4'h8;
      endcase
   end

   assign wr_word.eop  = beat.last;
   assign wr_word.code = strb_code;
   assign wr_word.data = beat.data;

   tx_frame_fifo u_fifo (
      .clk156      (clk156),
      .reset       (reset),
      .wr_en       (wr_en),
      .wdata       (wr_word),
      .rd_en       (rd_en),
      .rdata       (rd_word),
      .empty       (fifo_empty),
      .almost_full (almost_full)
   );

   // Complete frames waiting for the MAC
   assign frame_done = wr_en & beat.last;
   assign frame_take = (state == mac_pkg::IDLE) && (frame_cnt != '0);

   always_ff @(posedge clk156) begin
      if (reset) begin
         frame_cnt <= '0;
      end else begin
         case ({frame_done, frame_take})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: frame_cnt <= frame_cnt;
         endcase
      end
   end

   // ********************
   // Read side
   // ********************
   always_comb begin
      case (rd_word.code)
         4'h0:    valid_mask = 8'h01;
         4'h1:    valid_mask = 8'h03;
         4'h2:    valid_mask = 8'h07;
         4'h3:    valid_mask = 8'h0f;
         4'h4:    valid_mask = 8'h1f;
         4'h5:    valid_mask = 8'h3f;
         4'h6:    valid_mask = 8'h7f;
         4'h7:    valid_mask = 8'hff;
         default: valid_mask = 8'h00;
      endcase
   end

   always_comb begin
      state_next    = state;
      rd_en         = 1'b0;
      mac_out.data  = rd_word.data;
      mac_out.valid = '0;
      case (state)
         mac_pkg::IDLE: begin
            if (frame_cnt != '0) begin
               state_next = mac_pkg::WAIT_FOR_ACK;
            end
         end
         mac_pkg::WAIT_FOR_ACK: begin
            if (tx_ack) begin
               state_next = mac_pkg::SEND_PKT;
            end
         end
         mac_pkg::SEND_PKT: begin
            // One word per cycle until the stored eop
            rd_en         = 1'b1;
            mac_out.valid = valid_mask;
            if (rd_word.eop) begin
               state_next = mac_pkg::IFG;
            end
         end
         mac_pkg::IFG: begin
            state_next = mac_pkg::IDLE;
         end
         default: begin
            state_next = mac_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         state <= mac_pkg::IDLE;
      end else begin
         state <= state_next;
      end
   end

   assign tx_start  = (state == mac_pkg::WAIT_FOR_ACK);
   assign tx_active = (state == mac_pkg::WAIT_FOR_ACK) || (state == mac_pkg::SEND_PKT);

   // Frame counting must guarantee the whole frame is stored before sending
   a_send_not_empty : assert property (@(posedge clk156) disable iff (reset)
      (state == mac_pkg::SEND_PKT) |-> !fifo_empty)
      else $error("queue FIFO ran dry during SEND_PKT");

endmodule

`default_nettype wire

//--- mac_tx_arbiter.sv
// ********************
// Round-robin owner of the single MAC interface
// One queue at a time sees tx_ack and drives tx_data
// ********************
`default_nettype none

module mac_tx_arbiter (
   input  wire logic                           clk156,
   input  wire logic                           reset,
   input  wire logic [axis_pkg::NUM_PORTS-1:0] q_start,
   input  wire logic [axis_pkg::NUM_PORTS-1:0] q_active,
   input  wire mac_pkg::mac_word_t             q_word [axis_pkg::NUM_PORTS],
   input  wire logic                           tx_ack,
   output logic [axis_pkg::NUM_PORTS-1:0]      q_ack,
   output logic                                tx_start,
   output axis_pkg::data_t                     tx_data,
   output mac_pkg::byte_valid_t                tx_data_valid,
   output axis_pkg::port_t                     tx_port
);

   logic            grant_valid;
   axis_pkg::port_t grant_idx;
   axis_pkg::port_t rr_ptr;
   logic            next_found;
   axis_pkg::port_t next_idx;

   // First requester at or after the round-robin pointer
   always_comb begin
      axis_pkg::port_t cand;
      next_found = 1'b0;
      next_idx   = rr_ptr;
      for (int i = 0; i < axis_pkg::NUM_PORTS; i++) begin
         cand = axis_pkg::port_t'((int'(rr_ptr) + i) % axis_pkg::NUM_PORTS);
         if (!next_found && q_start[cand]) begin
            next_found = 1'b1;
            next_idx   = cand;
         end
      end
   end

   always_ff @(posedge clk156) begin
      if (reset) begin
         grant_valid <= 1'b0;
         grant_idx   <= '0;
         rr_ptr      <= '0;
      end else if (!grant_valid) begin
         if (next_found) begin
            grant_valid <= 1'b1;
            grant_idx   <= next_idx;
         end
      end else if (!q_active[grant_idx]) begin
         // Served port goes to the back of the line
         grant_valid <= 1'b0;
         rr_ptr      <= axis_pkg::port_t'((int'(grant_idx) + 1) % axis_pkg::NUM_PORTS);
      end
   end

   always_comb begin
      q_ack = '0;
      q_ack[grant_idx] = grant_valid & tx_ack;
   end

   assign tx_start      = grant_valid & q_start[grant_idx];
   assign tx_data       = q_word[grant_idx].data;
   assign tx_data_valid = grant_valid ? q_word[grant_idx].valid : '0;
   assign tx_port       = grant_idx;

   // MAC must only acknowledge a pending request
   a_ack_with_start : assert property (@(posedge clk156) disable iff (reset)
      tx_ack |-> tx_start)
      else $error("tx_ack without tx_start");

endmodule

`default_nettype wire

//--- tx_subsystem_top.sv
// ********************
// Four-port 10G MAC transmit path
// Stream in, distributor, per-port queues, arbiter, MAC out
// ********************
`default_nettype none

module tx_subsystem_top (
   input  wire logic                 clk156,
   input  wire logic                 reset,
   input  wire axis_pkg::data_t      tdata,
   input  wire axis_pkg::strb_t      tstrb,
   input  wire logic                 tvalid,
   input  wire logic                 tlast,
   input  wire axis_pkg::port_t      tdest,
   output logic                      tready,
   output axis_pkg::data_t           tx_data,
   output mac_pkg::byte_valid_t      tx_data_valid,
   output logic                      tx_start,
   input  wire logic                 tx_ack,
   output axis_pkg::port_t           tx_port
);

   axis_pkg::axis_beat_t             beat;
   logic [axis_pkg::NUM_PORTS-1:0]   wr_en;
   logic [axis_pkg::NUM_PORTS-1:0]   q_almost_full;
   logic [axis_pkg::NUM_PORTS-1:0]   q_start;
   logic [axis_pkg::NUM_PORTS-1:0]   q_active;
   logic [axis_pkg::NUM_PORTS-1:0]   q_ack;
   mac_pkg::mac_word_t               q_word [axis_pkg::NUM_PORTS];

   frame_distributor u_dist (
      .clk156      (clk156),
      .reset       (reset),
      .tdata       (tdata),
      .tstrb       (tstrb),
      .tvalid      (tvalid),
      .tlast       (tlast),
      .tdest       (tdest),
      .almost_full (q_almost_full),
      .tready      (tready),
      .beat        (beat),
      .wr_en       (wr_en)
   );

   for (genvar p = 0; p < axis_pkg::NUM_PORTS; p++) begin : g_queue
      tx_queue u_queue (
         .clk156      (clk156),
         .reset       (reset),
         .wr_en       (wr_en[p]),
         .beat        (beat),
         .tx_ack      (q_ack[p]),
         .almost_full (q_almost_full[p]),
         .tx_start    (q_start[p]),
         .tx_active   (q_active[p]),
         .mac_out     (q_word[p])
      );
   end

   mac_tx_arbiter u_arb (
      .clk156        (clk156),
      .reset         (reset),
      .q_start       (q_start),
      .q_active      (q_active),
      .q_word        (q_word),
      .tx_ack        (tx_ack),
      .q_ack         (q_ack),
      .tx_start      (tx_start),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_port       (tx_port)
   );

endmodule

`default_nettype wire

//--- tb_tx_subsystem.sv
// ********************
// Testbench for the four-port transmit path
// Random frames in, a MAC model that acks tx_start, per-port
// scoreboards and concurrent assertions on the MAC side
// ********************
`default_nettype none

module tb_tx_subsystem;
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic                 last;
      axis_pkg::data_t      data;
      mac_pkg::byte_valid_t valid;
   } exp_word_t;

   logic                 clk156;
   logic                 reset;
   axis_pkg::data_t      tdata;
   axis_pkg::strb_t      tstrb;
   logic                 tvalid;
   logic                 tlast;
   axis_pkg::port_t      tdest;
   logic                 tready;
   axis_pkg::data_t      tx_data;
   mac_pkg::byte_valid_t tx_data_valid;
   logic                 tx_start;
   logic                 tx_ack;
   axis_pkg::port_t      tx_port;

   // Expected MAC words per port, in send order
   exp_word_t sb [axis_pkg::NUM_PORTS][$];

   int   frames_in  [axis_pkg::NUM_PORTS] = '{default: 0};
   int   frames_out [axis_pkg::NUM_PORTS] = '{default: 0};
   logic beat_taken = 1'b0;
   logic ack_hold   = 1'b0;
   int   stall_cnt  = 0;

   // Monitor results updated mid-cycle and checked at the next edge
   logic            chk_word  = 1'b0;
   logic            word_ok   = 1'b0;
   logic            word_last = 1'b0;
   logic            rr_chk    = 1'b0;
   logic            rr_ok     = 1'b0;
   logic            out_busy  = 1'b0;
   logic            rr_armed  = 1'b0;
   axis_pkg::port_t rr_next   = '0;

   tx_subsystem_top u_dut (
      .clk156        (clk156),
      .reset         (reset),
      .tdata         (tdata),
      .tstrb         (tstrb),
      .tvalid        (tvalid),
      .tlast         (tlast),
      .tdest         (tdest),
      .tready        (tready),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_start      (tx_start),
      .tx_ack        (tx_ack),
      .tx_port       (tx_port)
   );

   initial begin
      clk156 = 1'b0;
      forever #10 clk156 = ~clk156;
   end

   task automatic abort_run(input string kind, input string msg);
      $display("%s at %0t ns: %s", kind, $time, msg);
      $display("sim failed");
      $fatal(1);
   endtask

   function automatic int sb_words();
      int total;
      total = 0;
      for (int p = 0; p < axis_pkg::NUM_PORTS; p++) begin
         total += sb[p].size();
      end
      return total;
   endfunction

   // True when every port except the served one has a complete frame stored
   function automatic logic others_pending(input axis_pkg::port_t served);
      logic all_busy;
      all_busy = 1'b1;
      for (int q = 0; q < axis_pkg::NUM_PORTS; q++) begin
         if (q != int'(served) && frames_in[q] <= frames_out[q]) begin
            all_busy = 1'b0;
         end
      end
      return all_busy;
   endfunction

   // ********************
   // Stream driver
   // ********************
   // Called on a falling edge and returns on the falling edge after acceptance
   task automatic send_beat(input axis_pkg::port_t port, input axis_pkg::data_t data,
                            input axis_pkg::strb_t strb, input logic last);
      int waited;
      tdest  = port;
      tdata  = data;
      tstrb  = strb;
      tlast  = last;
      tvalid = 1'b1;
      waited = 0;
      do begin
         @(negedge clk156);
         waited++;
         if (waited > 500) begin
            abort_run("Timeout", "stream beat was never accepted");
         end
      end while (!beat_taken);
      tvalid = 1'b0;
   endtask

   task automatic send_frame(input axis_pkg::port_t port, input int len);
      exp_word_t       w;
      axis_pkg::strb_t strb;
      for (int i = 0; i < len; i++) begin
         w.data = {$urandom, $urandom};
         w.last = (i == len - 1);
         // Last beat gets a random low-aligned strobe
         strb    = w.last ? (8'hff >> $urandom_range(7)) : 8'hff;
         w.valid = strb;
         sb[port].push_back(w);
         send_beat(port, w.data, strb, w.last);
      end
   endtask

   task automatic wait_drain(input int limit);
      int waited;
      waited = 0;
      @(posedge clk156);
      while (sb_words() != 0) begin
         @(posedge clk156);
         waited++;
         if (waited > limit) begin
            abort_run("Timeout", "expected frames never appeared at the MAC output");
         end
      end
      @(negedge clk156);
   endtask

   always @(posedge clk156) begin
      beat_taken <= tvalid && tready;
      if (!reset && tvalid && tready && tlast) begin
         frames_in[tdest] <= frames_in[tdest] + 1;
      end
   end

   // Cycles of tready low while acks are held
   // Twenty of them release the MAC
   always @(posedge clk156) begin
      if (!ack_hold) begin
         stall_cnt <= 0;
      end else if (!tready) begin
         stall_cnt <= stall_cnt + 1;
      end
   end

   // ********************
   // MAC model
   // ********************
   initial begin : mac_model
      int delay;
      delay  = -1;
      tx_ack = 1'b0;
      forever begin
         @(negedge clk156);
         tx_ack = 1'b0;
         if (reset || !tx_start || (ack_hold && stall_cnt < 20)) begin
            delay = -1;
         end else if (delay < 0) begin
            delay = $urandom_range(6);
         end
         if (delay == 0) begin
            tx_ack = 1'b1;
         end
         if (delay >= 0) begin
            delay--;
         end
      end
   end

   always @(negedge clk156) begin : out_monitor
      exp_word_t head;
      logic      found;
      chk_word <= 1'b0;
      rr_chk   <= 1'b0;
      if (!reset && tx_data_valid != '0) begin
         found = (sb[tx_port].size() != 0);
         head  = '0;
         if (found) begin
            head = sb[tx_port].pop_front();
         end
         chk_word  <= 1'b1;
         word_ok   <= found && head.data == tx_data && head.valid == tx_data_valid;
         word_last <= head.last;
         if (!out_busy) begin
            frames_out[tx_port] = frames_out[tx_port] + 1;
            rr_chk  <= rr_armed;
            rr_ok   <= (tx_port == rr_next);
            rr_armed = 1'b0;
         end
         out_busy = !head.last;
         if (head.last) begin
            rr_armed = others_pending(tx_port);
            rr_next  = tx_port + 2'd1;
         end
      end
   end

   // ********************
   // Checks
   // ********************
   a_reset_values : assert property (@(posedge clk156)
      $past(reset) |-> !tx_start && tx_data_valid == '0 && tready)
      else abort_run("Fail", "outputs not idle after reset");

   a_word_match : assert property (@(posedge clk156) disable iff (reset)
      chk_word |-> word_ok)
      else abort_run("Fail", "MAC word differs from scoreboard");

   a_first_after_ack : assert property (@(posedge clk156) disable iff (reset)
      tx_ack |=> tx_data_valid != '0)
      else abort_run("Fail", "no first word one cycle after tx_ack");

   a_ack_before_first : assert property (@(posedge clk156) disable iff (reset)
      (tx_data_valid != '0) && ($past(tx_data_valid) == '0) |-> $past(tx_ack))
      else abort_run("Fail", "frame started without tx_ack");

   a_idle_while_start : assert property (@(posedge clk156) disable iff (reset)
      tx_start |-> tx_data_valid == '0)
      else abort_run("Fail", "data valid while tx_start waits");

   a_contiguous : assert property (@(posedge clk156) disable iff (reset)
      chk_word && !word_last |=> chk_word)
      else abort_run("Fail", "gap inside a frame");

   a_gap_after_last : assert property (@(posedge clk156) disable iff (reset)
      chk_word && word_last |=> !chk_word)
      else abort_run("Fail", "valid right after last word");

   a_round_robin : assert property (@(posedge clk156) disable iff (reset)
      rr_chk |-> rr_ok)
      else abort_run("Fail", "round-robin order broken");

   initial begin : stimulus
      axis_pkg::port_t port;
      int              len;
      int              gap;
      void'($urandom(32'h4d00a804));
      reset  = 1'b1;
      tdata  = '0;
      tstrb  = '0;
      tvalid = 1'b0;
      tlast  = 1'b0;
      tdest  = '0;
      repeat (8) @(posedge clk156);
      @(negedge clk156);
      reset = 1'b0;

      // Random traffic with acks after a short random delay
      for (int f = 0; f < 60; f++) begin
         port = axis_pkg::port_t'($urandom_range(axis_pkg::NUM_PORTS - 1));
         len  = $urandom_range(24, 1);
         gap  = $urandom_range(2);
         send_frame(port, len);
         repeat (gap) @(negedge clk156);
      end
      wait_drain(4000);

      // Fill all ports while the MAC is silent so the arbiter must rotate
      ack_hold <= 1'b1;
      for (int r = 0; r < 2; r++) begin
         for (int p = 0; p < axis_pkg::NUM_PORTS; p++) begin
            len = $urandom_range(10, 1);
            send_frame(axis_pkg::port_t'(p), len);
         end
      end
      ack_hold <= 1'b0;
      wait_drain(2000);

      // One port overfilled with acks withheld
      ack_hold <= 1'b1;
      for (int f = 0; f < 6; f++) begin
         send_frame(axis_pkg::port_t'(1), 20);
      end
      a_tready_fell : assert (stall_cnt >= 20)
         else abort_run("Fail", "tready did not fall while acks were withheld");
      ack_hold <= 1'b0;
      wait_drain(4000);

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
axis_pkg.sv
mac_pkg.sv
frame_distributor.sv
tx_frame_fifo.sv
tx_queue.sv
mac_tx_arbiter.sv
tx_subsystem_top.sv
tb_tx_subsystem.sv

//--- Makefile
SRCS := $(shell cat filelist.f)
SIM  := obj_dir/Vtb_tx_subsystem

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_tx_subsystem -f filelist.f

run: $(SIM)
	./$(SIM) 2>&1 | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "sim passed" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
